/* logic/gb_io_pkg.sv */
//////////////////////////////////////////////////
// Game console I/O block shared definitions
// Register offsets, bus and control structs, IRQ union
//////////////////////////////////////////////////
`default_nettype none

package gb_io_pkg;

	// Register offsets in the I/O page
	localparam logic [7:0] addr_p1   = 8'h00;
	localparam logic [7:0] addr_div  = 8'h04;
	localparam logic [7:0] addr_tima = 8'h05;
	localparam logic [7:0] addr_tma  = 8'h06;
	localparam logic [7:0] addr_tac  = 8'h07;
	localparam logic [7:0] addr_if   = 8'h0f;
	localparam logic [7:0] addr_ie   = 8'hff;

	// Free-running system divider, DIV is its top byte
	localparam int sysdiv_w = 16;

	typedef struct packed {
		logic       sel;
		logic       enable;
		logic       write;
		logic [7:0] addr;
		logic [7:0] wdata;
	} apb_req_t;

	typedef struct packed {
		logic [7:0] rdata;
		logic       slverr;
	} apb_rsp_t;

	// Strobes plus the TAC and TMA contents
	typedef struct packed {
		logic       div_clear;
		logic       tima_load;
		logic [7:0] tima_value;
		logic       enable;
		logic [1:0] clk_sel;
		logic [7:0] modulo;
	} timer_ctrl_t;

	typedef struct packed {
		logic [7:0] div;
		logic [7:0] tima;
	} timer_stat_t;

	// All active low, released is 1
	typedef struct packed {
		logic start;
		logic select;
		logic b;
		logic a;
		logic down;
		logic up;
		logic left;
		logic right;
	} buttons_t;

	// IF/IE bit order, vblank is bit 0
	typedef struct packed {
		logic joypad;
		logic serial;
		logic timer;
		logic lcd;
		logic vblank;
	} irq_flags_t;

	typedef union packed {
		logic [4:0] vec;
		irq_flags_t flag;
	} irq_bits_u;

endpackage

`default_nettype wire

/* logic/io_regs.sv */
//////////////////////////////////////////////////
// I/O register block behind a zero-wait APB slave
// P1 selects, TMA, TAC, IF, IE and the read mux
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module io_regs (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire gb_io_pkg::apb_req_t    apb_req,
	output gb_io_pkg::apb_rsp_t         apb_rsp,
	output gb_io_pkg::timer_ctrl_t      timer_ctrl,
	input  wire gb_io_pkg::timer_stat_t timer_stat,
	input  wire logic                   timer_irq,
	output logic [1:0]                  joy_sel,
	input  wire logic [3:0]             joy_rows,
	input  wire logic                   joypad_irq,
	output logic                        irq_pending
);

	logic                 access;
	logic                 mapped;
	logic                 wr;
	logic [7:0]           rdata;
	logic [7:0]           tma;
	logic [2:0]           tac;
	gb_io_pkg::irq_bits_u if_q;
	gb_io_pkg::irq_bits_u ie_q;
	gb_io_pkg::irq_bits_u if_base;
	gb_io_pkg::irq_bits_u req;
	gb_io_pkg::irq_bits_u if_next;

	// Access phase always completes in one cycle
	assign access = apb_req.sel & apb_req.enable;
	assign wr     = access & apb_req.write & mapped;

	// Read mux and address decode
	always_comb begin
		mapped = 1'b1;
		case (apb_req.addr)
			gb_io_pkg::addr_p1:   rdata = {2'b11, joy_sel, joy_rows};
			gb_io_pkg::addr_div:  rdata = timer_stat.div;
			gb_io_pkg::addr_tima: rdata = timer_stat.tima;
			gb_io_pkg::addr_tma:  rdata = tma;
			gb_io_pkg::addr_tac:  rdata = {5'b11111, tac};
			gb_io_pkg::addr_if:   rdata = {3'b111, if_q.vec};
			gb_io_pkg::addr_ie:   rdata = {3'b111, ie_q.vec};
			default: begin
				rdata  = 8'h00;
				mapped = 1'b0;
			end
		endcase
	end

	assign apb_rsp.rdata  = rdata;
	assign apb_rsp.slverr = access & ~mapped;

	// Timer strobes are live only during the write access
	assign timer_ctrl.div_clear  = wr & (apb_req.addr == gb_io_pkg::addr_div);
	assign timer_ctrl.tima_load  = wr & (apb_req.addr == gb_io_pkg::addr_tima);
	assign timer_ctrl.tima_value = apb_req.wdata;
	assign timer_ctrl.enable     = tac[2];
	assign timer_ctrl.clk_sel    = tac[1:0];
	assign timer_ctrl.modulo     = tma;

	// Requests from the timer and joypad only, the rest stay quiet
	always_comb begin
		req.vec         = '0;
		req.flag.timer  = timer_irq;
		req.flag.joypad = joypad_irq;
	end

	// A request beats a clearing write to the same bit
	always_comb begin
		if (wr && apb_req.addr == gb_io_pkg::addr_if)
			if_base.vec = apb_req.wdata[4:0];
		else
			if_base.vec = if_q.vec;
		if_next.vec = if_base.vec | req.vec;
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			joy_sel     <= 2'b11;
			tma         <= '0;
			tac         <= '0;
			if_q.vec    <= '0;
			ie_q.vec    <= '0;
			irq_pending <= 1'b0;
		end else begin
			if (wr && apb_req.addr == gb_io_pkg::addr_p1)
				joy_sel <= apb_req.wdata[5:4];
			if (wr && apb_req.addr == gb_io_pkg::addr_tma)
				tma <= apb_req.wdata;
			if (wr && apb_req.addr == gb_io_pkg::addr_tac)
				tac <= apb_req.wdata[2:0];
			if (wr && apb_req.addr == gb_io_pkg::addr_ie)
				ie_q.vec <= apb_req.wdata[4:0];
			if_q <= if_next;
			// Pending lags IE and IF by one edge
			irq_pending <= |(ie_q.vec & if_q.vec);
		end
	end

endmodule

`default_nettype wire

/* logic/io_timer.sv */
//////////////////////////////////////////////////
// System divider and programmable TIMA timer
// Reloads from the modulo on overflow, raises a request
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module io_timer (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire gb_io_pkg::timer_ctrl_t timer_ctrl,
	output gb_io_pkg::timer_stat_t      timer_stat,
	output logic                        timer_irq
);

	logic [gb_io_pkg::sysdiv_w-1:0] sysdiv;
	logic [7:0]                     tima;
	logic                           rate_hit;
	logic                           tick;

	// Low divider bits all ones means the next edge carries past the rate bit
	always_comb begin
		case (timer_ctrl.clk_sel)
			2'd0:    rate_hit = &sysdiv[9:0];
			2'd1:    rate_hit = &sysdiv[3:0];
			2'd2:    rate_hit = &sysdiv[5:0];
			default: rate_hit = &sysdiv[7:0];
		endcase
	end

	// A DIV write swallows the tick of that edge
	assign tick = timer_ctrl.enable & rate_hit & ~timer_ctrl.div_clear;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			sysdiv <= '0;
		end else if (timer_ctrl.div_clear) begin
			sysdiv <= '0;
		end else begin
			sysdiv <= sysdiv + 1'b1;
		end
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			tima      <= '0;
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= 1'b0;
			if (timer_ctrl.tima_load) begin
				// Software load wins over a tick
				tima <= timer_ctrl.tima_value;
			end else if (tick) begin
				if (tima == 8'hff) begin
					tima      <= timer_ctrl.modulo;
					timer_irq <= 1'b1;
				end else begin
					tima <= tima + 8'd1;
				end
			end
		end
	end

	assign timer_stat.div  = sysdiv[gb_io_pkg::sysdiv_w-1 -: 8];
	assign timer_stat.tima = tima;

endmodule

`default_nettype wire

/* logic/joypad_matrix.sv */
//////////////////////////////////////////////////
// Joypad button matrix behind two row selects
// Synchronizes buttons and flags press edges
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module joypad_matrix (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire gb_io_pkg::buttons_t buttons,
	input  wire logic [1:0]          joy_sel,
	output logic [3:0]               joy_rows,
	output logic                     joypad_irq
);

	gb_io_pkg::buttons_t sync1;
	gb_io_pkg::buttons_t sync2;
	gb_io_pkg::buttons_t prev;

	// Two-stage synchronizer plus one stage for edge detection
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			sync1      <= '1;
			sync2      <= '1;
			prev       <= '1;
			joypad_irq <= 1'b0;
		end else begin
			sync1      <= buttons;
			sync2      <= sync1;
			prev       <= sync2;
			// Any 1 to 0 transition is a press
			joypad_irq <= |(prev & ~sync2);
		end
	end

	// sel[0] low enables the action group, sel[1] low the direction group
	assign joy_rows[3] = (joy_sel[0] | sync2.start)  & (joy_sel[1] | sync2.down);
	assign joy_rows[2] = (joy_sel[0] | sync2.select) & (joy_sel[1] | sync2.up);
	assign joy_rows[1] = (joy_sel[0] | sync2.b)      & (joy_sel[1] | sync2.left);
	assign joy_rows[0] = (joy_sel[0] | sync2.a)      & (joy_sel[1] | sync2.right);

endmodule

`default_nettype wire

/* logic/gb_io_top.sv */
//////////////////////////////////////////////////
// Game console I/O peripheral block top level
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module gb_io_top (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire gb_io_pkg::apb_req_t apb_req,
	output gb_io_pkg::apb_rsp_t      apb_rsp,
	input  wire gb_io_pkg::buttons_t buttons,
	output logic                     irq_pending
);

	gb_io_pkg::timer_ctrl_t timer_ctrl;
	gb_io_pkg::timer_stat_t timer_stat;
	logic                   timer_irq;
	logic [1:0]             joy_sel;
	logic [3:0]             joy_rows;
	logic                   joypad_irq;

	io_regs io_regs_i (
		.clk         (clk),
		.rst         (rst),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.timer_ctrl  (timer_ctrl),
		.timer_stat  (timer_stat),
		.timer_irq   (timer_irq),
		.joy_sel     (joy_sel),
		.joy_rows    (joy_rows),
		.joypad_irq  (joypad_irq),
		.irq_pending (irq_pending)
	);

	io_timer io_timer_i (
		.clk        (clk),
		.rst        (rst),
		.timer_ctrl (timer_ctrl),
		.timer_stat (timer_stat),
		.timer_irq  (timer_irq)
	);

	joypad_matrix joypad_matrix_i (
		.clk        (clk),
		.rst        (rst),
		.buttons    (buttons),
		.joy_sel    (joy_sel),
		.joy_rows   (joy_rows),
		.joypad_irq (joypad_irq)
	);

endmodule

`default_nettype wire

/* tb/gb_io_tb.sv */
//////////////////////////////////////////////////
// Testbench for the I/O peripheral block
// Random APB and button stimulus against a cycle model
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module gb_io_tb;

	localparam int num_steps   = 1500;
	localparam int cycle_limit = num_steps * 3 + 100;

	logic                clk;
	logic                rst;
	gb_io_pkg::apb_req_t apb_req;
	gb_io_pkg::apb_rsp_t apb_rsp;
	gb_io_pkg::buttons_t buttons;
	logic                irq_pending;
	logic [31:0]         lfsr;
	int                  cycle_count = 0;

	// Model state after the latest rising edge
	logic [gb_io_pkg::sysdiv_w-1:0] m_div;
	logic [7:0]                     m_tima;
	logic [7:0]                     m_tma;
	logic [2:0]                     m_tac;
	logic [1:0]                     m_sel;
	gb_io_pkg::irq_bits_u           m_if;
	gb_io_pkg::irq_bits_u           m_ie;
	gb_io_pkg::buttons_t            m_sync1;
	gb_io_pkg::buttons_t            m_sync2;
	gb_io_pkg::buttons_t            m_prev;
	logic                           m_timer_irq;
	logic                           m_joy_irq;
	logic                           m_pending;

	gb_io_top gb_io_top_i (
		.clk         (clk),
		.rst         (rst),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.buttons     (buttons),
		.irq_pending (irq_pending)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (!rst) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit) begin
				$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
				$display("** FAIL **");
				$fatal(1, "timeout");
			end
		end
	end

	task automatic check_value(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s got %02h, expected %02h",
				$time, name, actual, expected);
			$display("** FAIL **");
			$fatal(1, "check failed");
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1, stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic        fb;
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [7:0] addr_by_index(input logic [2:0] idx);
		case (idx)
			3'd0:    return gb_io_pkg::addr_p1;
			3'd1:    return gb_io_pkg::addr_div;
			3'd2:    return gb_io_pkg::addr_tima;
			3'd3:    return gb_io_pkg::addr_tma;
			3'd4:    return gb_io_pkg::addr_tac;
			3'd5:    return gb_io_pkg::addr_if;
			default: return gb_io_pkg::addr_ie;
		endcase
	endfunction

	function automatic logic is_mapped(input logic [7:0] addr);
		for (int i = 0; i < 7; i++)
			if (addr_by_index(3'(i)) == addr)
				return 1'b1;
		return 1'b0;
	endfunction

	// A low select enables its group and a pressed button pulls its row low
	function automatic logic [3:0] row_nibble(input gb_io_pkg::buttons_t btn,
			input logic [1:0] sel);
		logic [3:0] rows;
		rows = 4'hf;
		if (!sel[0])
			rows = rows & {btn.start, btn.select, btn.b, btn.a};
		if (!sel[1])
			rows = rows & {btn.down, btn.up, btn.left, btn.right};
		return rows;
	endfunction

	function automatic logic rate_reached(input logic [gb_io_pkg::sysdiv_w-1:0] div,
			input logic [1:0] clk_sel);
		int                             width;
		logic [gb_io_pkg::sysdiv_w-1:0] mask;
		case (clk_sel)
			2'd0:    width = 10;
			2'd1:    width = 4;
			2'd2:    width = 6;
			default: width = 8;
		endcase
		mask = '1 >> (gb_io_pkg::sysdiv_w - width);
		return (div & mask) == mask;
	endfunction

	function automatic logic [7:0] expected_read(input logic [7:0] addr);
		case (addr)
			gb_io_pkg::addr_p1:   return {2'b11, m_sel, row_nibble(m_sync2, m_sel)};
			gb_io_pkg::addr_div:  return m_div[gb_io_pkg::sysdiv_w-1 -: 8];
			gb_io_pkg::addr_tima: return m_tima;
			gb_io_pkg::addr_tma:  return m_tma;
			gb_io_pkg::addr_tac:  return {5'b11111, m_tac};
			gb_io_pkg::addr_if:   return {3'b111, m_if.vec};
			default:              return {3'b111, m_ie.vec};
		endcase
	endfunction

	// Drive, check and step the model for one cycle from a falling edge
	task automatic drive_cycle(input gb_io_pkg::apb_req_t req,
			input gb_io_pkg::buttons_t btn);
		logic                 access;
		logic                 mapped;
		logic                 wr;
		gb_io_pkg::irq_bits_u reqs;

		apb_req = req;
		buttons = btn;
		#1;
		access = req.sel & req.enable;
		mapped = is_mapped(req.addr);
		wr     = access & req.write & mapped;
		check_value("irq_pending", 8'(irq_pending), 8'(m_pending));
		check_value("slverr", 8'(apb_rsp.slverr), 8'(access & ~mapped));
		if (access && !req.write && mapped)
			check_value($sformatf("rdata[%02h]", req.addr), apb_rsp.rdata,
				expected_read(req.addr));
		// Request pulses of the previous edge land in IF
		reqs.vec         = '0;
		reqs.flag.timer  = m_timer_irq;
		reqs.flag.joypad = m_joy_irq;
		m_pending        = |(m_ie.vec & m_if.vec);
		if (wr && req.addr == gb_io_pkg::addr_if)
			m_if.vec = req.wdata[4:0];
		m_if.vec = m_if.vec | reqs.vec;
		m_timer_irq = 1'b0;
		if (wr && req.addr == gb_io_pkg::addr_tima) begin
			m_tima = req.wdata;
		end else if (m_tac[2] && rate_reached(m_div, m_tac[1:0]) &&
				!(wr && req.addr == gb_io_pkg::addr_div)) begin
			m_timer_irq = (m_tima == 8'hff);
			m_tima      = m_timer_irq ? m_tma : m_tima + 8'd1;
		end
		if (wr && req.addr == gb_io_pkg::addr_div)
			m_div = '0;
		else
			m_div = m_div + 1'b1;
		m_joy_irq = |(m_prev & ~m_sync2);
		m_prev    = m_sync2;
		m_sync2   = m_sync1;
		m_sync1   = btn;
		if (wr) begin
			case (req.addr)
				gb_io_pkg::addr_p1:  m_sel = req.wdata[5:4];
				gb_io_pkg::addr_tma: m_tma = req.wdata;
				gb_io_pkg::addr_tac: m_tac = req.wdata[2:0];
				gb_io_pkg::addr_ie:  m_ie.vec = req.wdata[4:0];
				default: ;
			endcase
		end
		@(negedge clk);
	endtask

	task automatic apb_access(input logic is_write, input logic [7:0] addr,
			input logic [7:0] wdata, input gb_io_pkg::buttons_t btn);
		gb_io_pkg::apb_req_t req;

		req = '{sel: 1'b1, enable: 1'b0, write: is_write, addr: addr, wdata: wdata};
		drive_cycle(req, btn);
		req.enable = 1'b1;
		drive_cycle(req, btn);
	endtask

	// Access phase lands on an edge where rate 1 ticks, then TIMA is read back
	task automatic write_on_tick(input logic [7:0] addr, input logic [7:0] wdata);
		while (m_div[3:0] != 4'he)
			drive_cycle('0, buttons);
		apb_access(1'b1, addr, wdata, buttons);
		apb_access(1'b0, gb_io_pkg::addr_tima, 8'h00, buttons);
	endtask

	task automatic random_step;
		logic [31:0]         r;
		logic [7:0]          addr;
		logic [7:0]          wdata;
		logic                is_write;
		gb_io_pkg::buttons_t btn;

		btn = buttons;
		r = take_bits(2);
		if (r[1:0] == 2'd0) begin
			r = take_bits(8);
			btn = btn ^ r[7:0];
		end
		r = take_bits(2);
		if (r[1:0] == 2'd0) begin
			drive_cycle('0, btn);
		end else begin
			r = take_bits(3);
			addr = addr_by_index(r[2:0]);
			// Index 7 picks a random and mostly unmapped address
			if (r[2:0] == 3'd7) begin
				r = take_bits(8);
				addr = r[7:0];
			end
			r = take_bits(9);
			is_write = r[8];
			wdata    = r[7:0];
			// Values near FF make TIMA overflow often
			if (addr == gb_io_pkg::addr_tima && wdata[7])
				wdata[7:3] = 5'b11111;
			// Rare DIV writes so slow rates still tick
			if (addr == gb_io_pkg::addr_div && wdata[6:3] != 4'd0)
				is_write = 1'b0;
			apb_access(is_write, addr, wdata, btn);
		end
	endtask

	initial begin
		lfsr        = 32'hca907289;
		rst         = 1'b1;
		apb_req     = '0;
		buttons     = '1;
		m_div       = '0;
		m_tima      = '0;
		m_tma       = '0;
		m_tac       = '0;
		m_sel       = 2'b11;
		m_if.vec    = '0;
		m_ie.vec    = '0;
		m_sync1     = '1;
		m_sync2     = '1;
		m_prev      = '1;
		m_timer_irq = 1'b0;
		m_joy_irq   = 1'b0;
		m_pending   = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Reset values of every register
		for (int i = 0; i < 7; i++)
			apb_access(1'b0, addr_by_index(3'(i)), 8'h00, buttons);
		// TIMA load and DIV clear on a tick edge at the fastest rate
		apb_access(1'b1, gb_io_pkg::addr_tac, 8'h05, buttons);
		write_on_tick(gb_io_pkg::addr_tima, 8'h3c);
		write_on_tick(gb_io_pkg::addr_div, 8'h00);
		for (int i = 0; i < num_steps; i++)
			random_step();
		for (int i = 0; i < 7; i++)
			apb_access(1'b0, addr_by_index(3'(i)), 8'h00, buttons);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
logic/gb_io_pkg.sv
logic/io_regs.sv
logic/io_timer.sv
logic/joypad_matrix.sv
logic/gb_io_top.sv
tb/gb_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the I/O block testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module gb_io_tb -f flist.f -o gb_io_sim
./obj_dir/gb_io_sim | tee sim.log
if grep -qF "** PASS **" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
